// File: common/motion_config.svh
`ifndef MOTION_CONFIG_SVH
`define MOTION_CONFIG_SVH

// channel counts
`define N_ENDSTOPS  4
`define N_SPEEDS    4
`define N_MOTORS    4

// datapath widths
`define POS_BITS    20
`define ACC_BITS    32   // accumulator and velocity

`define SYNC_STAGES 2    // endstop input synchronizer depth

`endif

// File: common/motion_pkg.sv
`default_nettype none

`include "motion_config.svh"

package motion_pkg;

    typedef logic signed [`ACC_BITS-1:0] vel_t;   // steps per 2^step_bit cycles
    typedef logic [`POS_BITS-1:0] pos_t;
    typedef logic [31:0] cnt_t;                    // cycle counts
    typedef logic [4:0] bit_sel_t;                 // accumulator bit index
    typedef logic [1:0] spd_sel_t;
    typedef logic [1:0] es_sel_t;

    typedef enum logic [1:0] {
        PS_IDLE,
        PS_PRE,
        PS_PULSE,
        PS_POST
    } pulse_state_t;

endpackage

`default_nettype wire

// File: common/motion_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "motion_config.svh"

interface motion_if;

    logic [`N_ENDSTOPS-1:0] holds;    // endstop locked levels
    logic [`N_ENDSTOPS-1:0] es_stbs;  // one cycle on lock
    logic [`N_SPEEDS-1:0]   steps;    // one cycle step strobes
    logic [`N_SPEEDS-1:0]   dirs;

    modport es_src (
        output holds,
        output es_stbs
    );

    modport sp_src (
        output steps,
        output dirs
    );

    modport motor (
        input holds,
        input es_stbs,
        input steps,
        input dirs
    );

endinterface

`default_nettype wire

// File: endstops/endstop_filter.sv
`timescale 1ns/100ps
`default_nettype none

`include "motion_config.svh"

module endstop_filter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`N_ENDSTOPS-1:0] es_in,
    input  motion_pkg::cnt_t       es_timeout,
    input  logic                   es_unlock,
    output logic [`N_ENDSTOPS-1:0] es_signal,
    output logic [`N_ENDSTOPS-1:0] es_locked,
    motion_if.es_src               bus
);
    import motion_pkg::*;

    genvar i;
    generate
        for (i = 0; i < `N_ENDSTOPS; i++) begin : g_ch
            logic [`SYNC_STAGES-1:0] sync;
            cnt_t cnt;           // consecutive high cycles
            logic lock;
            logic stb;
            logic sync_hi;
            logic lock_set;

            assign sync_hi  = sync[`SYNC_STAGES-1];
            assign lock_set = sync_hi && !lock && (cnt == es_timeout) && !es_unlock;

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    sync <= '0;
                    cnt  <= '0;
                    lock <= 1'b0;
                    stb  <= 1'b0;
                end else begin
                    sync <= {sync[`SYNC_STAGES-2:0], es_in[i]};
                    stb  <= lock_set;
                    if (es_unlock) begin
                        lock <= 1'b0;
                        cnt  <= '0;
                    end else if (!sync_hi) begin
                        cnt <= '0;            // bounce restarts the timeout
                    end else if (lock_set) begin
                        lock <= 1'b1;
                    end else if (!lock) begin
                        cnt <= cnt + 1'b1;
                    end
                end
            end

            assign es_signal[i]   = sync_hi;
            assign es_locked[i]   = lock;
            assign bus.holds[i]   = lock;
            assign bus.es_stbs[i] = stb;

            a_stb_on_lock: assert property (@(posedge clk) disable iff (!rst_n)
                stb |-> lock && !$past(lock));
        end
    endgenerate

endmodule

`default_nettype wire

// File: source/speed_integrator.sv
`timescale 1ns/100ps
`default_nettype none

`include "motion_config.svh"

module speed_integrator (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load_speeds,
    input  motion_pkg::vel_t     vel,
    input  motion_pkg::bit_sel_t step_bit,
    output logic                 step,
    output logic                 dir
);
    import motion_pkg::*;

    vel_t v;      // loaded velocity
    vel_t acc;
    logic bit_q;  // selected bit, one cycle late

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v     <= '0;
            acc   <= '0;
            bit_q <= 1'b0;
            step  <= 1'b0;
        end else if (load_speeds) begin
            v     <= vel;
            acc   <= '0;
            bit_q <= 1'b0;
            step  <= 1'b0;
        end else begin
            acc   <= acc + v;
            bit_q <= acc[step_bit];
            step  <= acc[step_bit] ^ bit_q;  // any toggle is one crossing
        end
    end

    // negative velocity crosses zero at once, hence the rounding up
    assign dir = v[`ACC_BITS-1];

endmodule

`default_nettype wire

// File: motor/step_pulse_gen.sv
`timescale 1ns/100ps
`default_nettype none

module step_pulse_gen (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stb,
    input  logic             stb_dir,
    input  motion_pkg::cnt_t pre_n,
    input  motion_pkg::cnt_t pulse_n,
    input  motion_pkg::cnt_t post_n,
    output logic             idle,
    output logic             step,
    output logic             dir
);
    import motion_pkg::*;

    pulse_state_t state;
    cnt_t cnt;    // one based, each phase lasts at least a cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= PS_IDLE;
            cnt   <= '0;
            step  <= 1'b0;
            dir   <= 1'b0;
        end else begin
            unique case (state)
                PS_IDLE: begin
                    if (stb) begin
                        dir   <= stb_dir;   // held for the whole pulse
                        cnt   <= 32'd1;
                        state <= PS_PRE;
                    end
                end
                PS_PRE: begin
                    if (cnt >= pre_n) begin
                        cnt   <= 32'd1;
                        step  <= 1'b1;
                        state <= PS_PULSE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                PS_PULSE: begin
                    if (cnt >= pulse_n) begin
                        cnt   <= 32'd1;
                        step  <= 1'b0;
                        state <= PS_POST;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                PS_POST: begin
                    if (cnt >= post_n) begin
                        cnt   <= '0;
                        state <= PS_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    assign idle = (state == PS_IDLE);  // strobes elsewhere are dropped

    a_step_in_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        step |-> state == PS_PULSE);

endmodule

`default_nettype wire

// File: motor/motor_channel.sv
`timescale 1ns/100ps
`default_nettype none

module motor_channel (
    input  logic                 clk,
    input  logic                 rst_n,
    motion_if.motor              bus,
    input  motion_pkg::spd_sel_t src_sel,
    input  motion_pkg::es_sel_t  es_sel,
    input  logic                 es_en,
    input  logic                 invert_dir,
    input  logic                 set_pos,
    input  motion_pkg::pos_t     pos_val,
    input  motion_pkg::cnt_t     pre_n,
    input  motion_pkg::cnt_t     pulse_n,
    input  motion_pkg::cnt_t     post_n,
    output logic                 step,
    output logic                 dir,
    output motion_pkg::pos_t     pos,
    output motion_pkg::pos_t     pos_hold
);

    logic sel_step;
    logic dir_eff;
    logic hold;
    logic hold_start;
    logic gen_idle;
    logic accept;

    assign sel_step   = bus.steps[src_sel];
    assign dir_eff    = bus.dirs[src_sel] ^ invert_dir;
    assign hold       = bus.holds[es_sel] & es_en;
    assign hold_start = bus.es_stbs[es_sel] & es_en;  // lock just rose
    assign accept     = sel_step & ~hold & gen_idle;

    step_pulse_gen u_pulse (
        .clk     (clk),
        .rst_n   (rst_n),
        .stb     (accept),
        .stb_dir (dir_eff),
        .pre_n   (pre_n),
        .pulse_n (pulse_n),
        .post_n  (post_n),
        .idle    (gen_idle),
        .step    (step),
        .dir     (dir)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos      <= '0;
            pos_hold <= '0;
        end else begin
            if (set_pos) begin
                pos <= pos_val;
            end else if (accept) begin
                pos <= dir_eff ? pos - 1'b1 : pos + 1'b1;  // dir 1 counts down
            end
            if (hold_start) begin
                pos_hold <= pos;
            end
        end
    end

    a_pos_frozen: assert property (@(posedge clk) disable iff (!rst_n)
        hold && !set_pos |=> $stable(pos));

endmodule

`default_nettype wire

// File: source/motion_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "motion_config.svh"

module motion_core (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [`N_ENDSTOPS-1:0]                 es_in,
    input  motion_pkg::cnt_t                       es_timeout,
    input  logic                                   es_unlock,
    input  logic                                   load_speeds,
    input  motion_pkg::vel_t [`N_SPEEDS-1:0]       vel_flat,
    input  motion_pkg::bit_sel_t                   step_bit,
    input  motion_pkg::cnt_t                       pre_n,
    input  motion_pkg::cnt_t                       pulse_n,
    input  motion_pkg::cnt_t                       post_n,
    input  motion_pkg::spd_sel_t [`N_MOTORS-1:0]   src_sel_flat,
    input  motion_pkg::es_sel_t [`N_MOTORS-1:0]    es_sel_flat,
    input  logic [`N_MOTORS-1:0]                   es_en,
    input  logic [`N_MOTORS-1:0]                   invert_dir,
    input  logic [`N_MOTORS-1:0]                   motor_disable,
    input  logic                                   set_pos,
    input  logic [`N_MOTORS-1:0]                   set_pos_en,
    input  motion_pkg::pos_t                       pos_val,
    output logic [`N_ENDSTOPS-1:0]                 es_signal,
    output logic [`N_ENDSTOPS-1:0]                 es_locked,
    output logic [`N_MOTORS-1:0]                   mot_step,
    output logic [`N_MOTORS-1:0]                   mot_dir,
    output logic [`N_MOTORS-1:0]                   mot_enable,
    output motion_pkg::pos_t [`N_MOTORS-1:0]       pos_flat,
    output motion_pkg::pos_t [`N_MOTORS-1:0]       pos_hold_flat
);

    motion_if bus ();

    endstop_filter u_endstops (
        .clk        (clk),
        .rst_n      (rst_n),
        .es_in      (es_in),
        .es_timeout (es_timeout),
        .es_unlock  (es_unlock),
        .es_signal  (es_signal),
        .es_locked  (es_locked),
        .bus        (bus)
    );

    genvar s, m;
    generate
        for (s = 0; s < `N_SPEEDS; s++) begin : g_speed
            speed_integrator u_speed (
                .clk         (clk),
                .rst_n       (rst_n),
                .load_speeds (load_speeds),
                .vel         (vel_flat[s]),
                .step_bit    (step_bit),
                .step        (bus.steps[s]),
                .dir         (bus.dirs[s])
            );
        end

        for (m = 0; m < `N_MOTORS; m++) begin : g_motor
            motor_channel u_motor (
                .clk        (clk),
                .rst_n      (rst_n),
                .bus        (bus),
                .src_sel    (src_sel_flat[m]),
                .es_sel     (es_sel_flat[m]),
                .es_en      (es_en[m]),
                .invert_dir (invert_dir[m]),
                .set_pos    (set_pos & set_pos_en[m]),  // preset only selected motors
                .pos_val    (pos_val),
                .pre_n      (pre_n),
                .pulse_n    (pulse_n),
                .post_n     (post_n),
                .step       (mot_step[m]),
                .dir        (mot_dir[m]),
                .pos        (pos_flat[m]),
                .pos_hold   (pos_hold_flat[m])
            );
        end
    endgenerate

    assign mot_enable = ~motor_disable;  // driver enables are active high

endmodule

`default_nettype wire

// File: verification/motion_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "motion_config.svh"

module motion_checker (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [`N_ENDSTOPS-1:0]            es_in,
    input  logic [`N_ENDSTOPS-1:0]            es_signal,
    input  logic [`N_MOTORS-1:0]              mot_step,
    input  logic [`N_MOTORS-1:0]              mot_dir,
    input  logic [`N_MOTORS-1:0]              mot_enable,
    input  logic [`N_ENDSTOPS-1:0]            es_locked,
    input  motion_pkg::pos_t [`N_MOTORS-1:0]  pos_flat,
    input  motion_pkg::pos_t [`N_MOTORS-1:0]  pos_hold_flat,
    input  logic                              clr,
    input  logic                              cmp,
    input  logic [`N_MOTORS-1:0][15:0]        exp_cnt,
    input  logic [`N_MOTORS-1:0]              exp_dir,
    input  motion_pkg::pos_t [`N_MOTORS-1:0]  exp_pos,
    input  motion_pkg::pos_t [`N_MOTORS-1:0]  exp_hold,
    input  logic [`N_MOTORS-1:0]              hold_mask,
    input  logic [`N_ENDSTOPS-1:0]            exp_locked,
    input  logic [`N_MOTORS-1:0]              exp_enable,
    output int                                errors
);
    import motion_pkg::*;

    logic [`N_MOTORS-1:0] step_q;
    int                   edges [`N_MOTORS];   // rising edges since clr
    logic [`SYNC_STAGES-1:0][`N_ENDSTOPS-1:0] es_hist;  // es_in over the last edges

    task automatic mismatch(input string sig, input int idx, input longint expv,
                            input longint got);
        errors++;
        $display("ERROR at %0t: %s[%0d] expected %0d, got %0d", $time, sig, idx, expv, got);
    endtask

    task automatic compare_all();
        for (int m = 0; m < `N_MOTORS; m++) begin
            if (edges[m] != int'(exp_cnt[m])) begin
                mismatch("mot_step rising edges", m, exp_cnt[m], edges[m]);
            end
            if (exp_cnt[m] != 0 && mot_dir[m] !== exp_dir[m]) begin
                mismatch("mot_dir", m, exp_dir[m], mot_dir[m]);
            end
            if (pos_flat[m] !== exp_pos[m]) begin
                mismatch("pos_flat", m, exp_pos[m], pos_flat[m]);
            end
            if (hold_mask[m] && pos_hold_flat[m] !== exp_hold[m]) begin
                mismatch("pos_hold_flat", m, exp_hold[m], pos_hold_flat[m]);
            end
            if (mot_enable[m] !== exp_enable[m]) begin
                mismatch("mot_enable", m, exp_enable[m], mot_enable[m]);
            end
        end
        for (int e = 0; e < `N_ENDSTOPS; e++) begin
            if (es_locked[e] !== exp_locked[e]) begin
                mismatch("es_locked", e, exp_locked[e], es_locked[e]);
            end
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_q  <= '0;
            es_hist <= '0;
            errors = 0;
            for (int m = 0; m < `N_MOTORS; m++) begin
                edges[m] <= 0;
            end
        end else begin
            step_q  <= mot_step;
            es_hist <= {es_hist[`SYNC_STAGES-2:0], es_in};
            // synchronized level lags the raw input by the sync depth
            for (int e = 0; e < `N_ENDSTOPS; e++) begin
                if (es_signal[e] !== es_hist[`SYNC_STAGES-1][e]) begin
                    mismatch("es_signal", e, es_hist[`SYNC_STAGES-1][e], es_signal[e]);
                end
            end
            for (int m = 0; m < `N_MOTORS; m++) begin
                if (clr) begin
                    edges[m] <= 0;
                end else if (mot_step[m] && !step_q[m]) begin
                    edges[m] <= edges[m] + 1;
                end
            end
            if (cmp) begin
                compare_all();   // outputs sampled before this edge updates them
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_motion_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "motion_config.svh"

module tb_motion_core;
    import motion_pkg::*;

    localparam int STEP_BIT   = 16;
    localparam int RUN_N      = 2000;                      // cycles per speed run
    localparam int RUN_CYCLES = RUN_N + 30;
    localparam int RUN_LIMIT  = 2 * (6 * RUN_CYCLES + 400);  // six runs plus endstop waits

    logic                       clk;
    logic                       rst_n;
    logic [`N_ENDSTOPS-1:0]     es_in;
    cnt_t                       es_timeout;
    logic                       es_unlock;
    logic                       load_speeds;
    vel_t [`N_SPEEDS-1:0]       vel_flat;
    bit_sel_t                   step_bit;
    cnt_t                       pre_n;
    cnt_t                       pulse_n;
    cnt_t                       post_n;
    spd_sel_t [`N_MOTORS-1:0]   src_sel_flat;
    es_sel_t [`N_MOTORS-1:0]    es_sel_flat;
    logic [`N_MOTORS-1:0]       es_en;
    logic [`N_MOTORS-1:0]       invert_dir;
    logic [`N_MOTORS-1:0]       motor_disable;
    logic                       set_pos;
    logic [`N_MOTORS-1:0]       set_pos_en;
    pos_t                       pos_val;
    logic [`N_ENDSTOPS-1:0]     es_signal;
    logic [`N_ENDSTOPS-1:0]     es_locked;
    logic [`N_MOTORS-1:0]       mot_step;
    logic [`N_MOTORS-1:0]       mot_dir;
    logic [`N_MOTORS-1:0]       mot_enable;
    pos_t [`N_MOTORS-1:0]       pos_flat;
    pos_t [`N_MOTORS-1:0]       pos_hold_flat;

    logic                       clr;
    logic                       cmp;
    logic [`N_MOTORS-1:0][15:0] exp_cnt;
    logic [`N_MOTORS-1:0]       exp_dir;
    pos_t [`N_MOTORS-1:0]       exp_pos;    // model of every motor position
    pos_t [`N_MOTORS-1:0]       exp_hold;
    logic [`N_MOTORS-1:0]       hold_mask;
    logic [`N_ENDSTOPS-1:0]     exp_locked;
    logic [`N_MOTORS-1:0]       exp_enable;
    vel_t [`N_SPEEDS-1:0]       vels;
    int                         errors;
    int                         err_mark;
    int                         n_pass;
    int                         n_fail;

    motion_core dut (.*);

    motion_checker u_check (.*);

    // strobes after a number of additions, one per multiple of 2^STEP_BIT crossed
    function automatic int expected_steps(vel_t v, int adds);
        longint span;
        longint unit;
        span = longint'(v) * adds;
        unit = longint'(1) << STEP_BIT;
        if (span >= 0) begin
            return int'(span / unit);
        end
        return int'((unit - 1 - span) / unit);  // negative rounds up
    endfunction

    function automatic pos_t expected_pos(pos_t start, int steps, logic down);
        if (down) begin
            return start - pos_t'(steps);
        end
        return start + pos_t'(steps);
    endfunction

    function automatic int rand_speed();
        return int'(1024 + $urandom % 3072);   // 16 cycles or more between strobes
    endfunction

    task automatic cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic compare_now();
        cmp = 1'b1;
        cycles(1);
        cmp = 1'b0;
        cycles(1);
    endtask

    task automatic step_run(input logic [`N_MOTORS-1:0] held);
        int n;
        vel_t v;
        clr = 1'b1;
        cycles(1);
        clr = 1'b0;
        vel_flat    = vels;
        load_speeds = 1'b1;
        cycles(1);
        load_speeds = 1'b0;
        cycles(RUN_N);
        vel_flat    = '0;
        load_speeds = 1'b1;   // zero velocity stops the integrators
        cycles(1);
        load_speeds = 1'b0;
        cycles(20);
        for (int m = 0; m < `N_MOTORS; m++) begin
            v = vels[src_sel_flat[m]];
            n = held[m] ? 0 : expected_steps(v, RUN_N - 1);  // reload eats the last strobe
            exp_cnt[m] = 16'(n);
            exp_dir[m] = v[`ACC_BITS-1] ^ invert_dir[m];
            exp_pos[m] = expected_pos(exp_pos[m], n, exp_dir[m]);
        end
        compare_now();
    endtask

    task automatic lock_endstop(input int e);
        es_in[e] = 1'b1;
        cycles(int'(es_timeout) + `SYNC_STAGES + 2);
        es_in[e] = 1'b0;
        exp_locked[e] = 1'b1;
    endtask

    task automatic unlock_all();
        es_unlock = 1'b1;
        cycles(1);
        es_unlock  = 1'b0;
        exp_locked = '0;
        cycles(2);
    endtask

    task automatic preset(input pos_t val, input logic [`N_MOTORS-1:0] sel);
        pos_val    = val;
        set_pos_en = sel;
        set_pos    = 1'b1;
        cycles(1);
        set_pos = 1'b0;
        for (int m = 0; m < `N_MOTORS; m++) begin
            if (sel[m]) begin
                exp_pos[m] = val;
            end
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == err_mark) begin
            n_pass++;
            $display("test %s: passed at %0t", name, $time);
        end else begin
            n_fail++;
            $display("test %s: FAILED with %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    task automatic new_speeds(input logic negative);
        for (int s = 0; s < `N_SPEEDS; s++) begin
            vels[s] = negative ? vel_t'(-rand_speed()) : vel_t'(rand_speed());
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(RUN_LIMIT * 8);
        $display("watchdog: tests did not finish within %0d cycles", RUN_LIMIT);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(28911));
        rst_n         = 1'b0;
        es_in         = '0;
        es_unlock     = 1'b0;
        load_speeds   = 1'b0;
        vel_flat      = '0;
        step_bit      = bit_sel_t'(STEP_BIT);
        pre_n         = 32'd2;
        pulse_n       = 32'd3;
        post_n        = 32'd2;
        src_sel_flat  = {2'd3, 2'd2, 2'd1, 2'd0};
        es_sel_flat   = '0;
        es_en         = '0;
        invert_dir    = '0;
        motor_disable = '0;
        set_pos       = 1'b0;
        set_pos_en    = '0;
        pos_val       = '0;
        clr           = 1'b0;
        cmp           = 1'b0;
        exp_cnt       = '0;
        exp_dir       = '0;
        exp_pos       = '0;
        exp_hold      = '0;
        hold_mask     = '0;
        exp_locked    = '0;
        exp_enable    = '1;   // all drivers enabled
        err_mark      = 0;
        n_pass        = 0;
        n_fail        = 0;
        es_timeout    = cnt_t'(5 + $urandom % 20);
        cycles(8);
        rst_n = 1'b1;
        cycles(2);

        new_speeds(1'b0);
        step_run('0);
        finish_test("step count");

        preset(20'h80000, '1);
        invert_dir = 4'b1100;
        new_speeds(1'b1);
        step_run('0);
        invert_dir = '0;
        finish_test("negative velocity and inversion");

        lock_endstop(0);
        cycles(4);
        compare_now();
        es_in[1] = 1'b1;
        cycles(int'(es_timeout));   // too short to lock
        es_in[1] = 1'b0;
        cycles(int'(es_timeout) + 8);
        compare_now();
        unlock_all();
        compare_now();
        finish_test("endstop lock");

        es_sel_flat = '0;
        es_en       = 4'b0001;
        new_speeds(1'b0);
        step_run('0);
        lock_endstop(0);
        cycles(2);
        exp_hold[0] = exp_pos[0];
        hold_mask   = 4'b0001;
        compare_now();
        step_run(4'b0001);
        unlock_all();
        step_run('0);
        es_en     = '0;
        hold_mask = '0;
        finish_test("endstop hold");

        src_sel_flat = {2'd1, 2'd0, 2'd3, 2'd2};
        new_speeds(1'b0);
        step_run('0);
        preset(pos_t'($urandom), 4'b0101);
        motor_disable = 4'b1010;
        exp_enable    = 4'b0101;
        cycles(1);
        compare_now();
        finish_test("mux and preset");

        $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
        if (n_fail == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: motion_core.f
+incdir+common
common/motion_pkg.sv
common/motion_if.sv
endstops/endstop_filter.sv
source/speed_integrator.sv
motor/step_pulse_gen.sv
motor/motor_channel.sv
source/motion_core.sv
verification/motion_checker.sv
verification/tb_motion_core.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the motion_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_motion_core \
    -f motion_core.f -o sim_motion_core > build.log 2>&1 \
    && ./obj_dir/sim_motion_core > sim.log 2>&1 \
    || { echo "build or run failed, see build.log and sim.log"; exit 1; }
grep -q "Simulation completed successfully" sim.log && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }
